// ==== design/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

   // widths
   localparam int NB_BITS    = 32;
   localparam int NB_REG     = 5;
   localparam int NB_JMP     = 28;  // jump index after the shift by 2
   localparam int NB_EXEC    = 9;   // alu_op(4) a_sel(2) b_sel(1) dst_sel(2)
   localparam int NB_FUNC    = 6;
   localparam int NB_EXT_SEL = 2;

   // primary opcodes
   localparam logic [5:0] OP_SPECIAL = 6'b000000;
   localparam logic [5:0] OP_J       = 6'b000010;
   localparam logic [5:0] OP_JAL     = 6'b000011;
   localparam logic [5:0] OP_BEQ     = 6'b000100;
   localparam logic [5:0] OP_BNE     = 6'b000101;
   localparam logic [5:0] OP_ADDI    = 6'b001000;
   localparam logic [5:0] OP_SLTI    = 6'b001010;
   localparam logic [5:0] OP_ANDI    = 6'b001100;
   localparam logic [5:0] OP_ORI     = 6'b001101;
   localparam logic [5:0] OP_XORI    = 6'b001110;
   localparam logic [5:0] OP_LUI     = 6'b001111;
   localparam logic [5:0] OP_LW      = 6'b100011;
   localparam logic [5:0] OP_SW      = 6'b101011;

   // function field of SPECIAL
   localparam logic [5:0] FN_SLL  = 6'b000000;
   localparam logic [5:0] FN_SRL  = 6'b000010;
   localparam logic [5:0] FN_SRA  = 6'b000011;
   localparam logic [5:0] FN_SLLV = 6'b000100;
   localparam logic [5:0] FN_SRLV = 6'b000110;
   localparam logic [5:0] FN_SRAV = 6'b000111;
   localparam logic [5:0] FN_JR   = 6'b001000;
   localparam logic [5:0] FN_JALR = 6'b001001;
   localparam logic [5:0] FN_ADDU = 6'b100001;
   localparam logic [5:0] FN_SUBU = 6'b100011;
   localparam logic [5:0] FN_AND  = 6'b100100;
   localparam logic [5:0] FN_OR   = 6'b100101;
   localparam logic [5:0] FN_XOR  = 6'b100110;
   localparam logic [5:0] FN_NOR  = 6'b100111;
   localparam logic [5:0] FN_SLT  = 6'b101010;

   // alu codes, ALU_FUNC hands the op over to the function field
   localparam logic [3:0] ALU_NONE = 4'd0;
   localparam logic [3:0] ALU_JAL  = 4'd1;
   localparam logic [3:0] ALU_ADD  = 4'd2;
   localparam logic [3:0] ALU_SLTI = 4'd3;
   localparam logic [3:0] ALU_ANDI = 4'd4;
   localparam logic [3:0] ALU_ORI  = 4'd5;
   localparam logic [3:0] ALU_XORI = 4'd6;
   localparam logic [3:0] ALU_LUI  = 4'd7;
   localparam logic [3:0] ALU_FUNC = 4'd8;

   // operand a / operand b / destination selects
   localparam logic [1:0] A_PC    = 2'd0;
   localparam logic [1:0] A_RS    = 2'd1;
   localparam logic [1:0] A_EXT   = 2'd2;
   localparam logic [1:0] A_NONE  = 2'd3;
   localparam logic       B_RT    = 1'b0;
   localparam logic       B_EXT   = 1'b1;
   localparam logic [1:0] DST_RD  = 2'd0;
   localparam logic [1:0] DST_RT  = 2'd1;
   localparam logic [1:0] DST_R31 = 2'd2;

   // immediate extend modes
   localparam logic [1:0] EXT_JMP   = 2'd0;
   localparam logic [1:0] EXT_SGN   = 2'd1;
   localparam logic [1:0] EXT_ZRO   = 2'd2;
   localparam logic [1:0] EXT_SHAMT = 2'd3;

   // one instruction word, three field layouts
   typedef union packed {
      struct packed {
         logic [5:0] op;
         logic [4:0] rs;
         logic [4:0] rt;
         logic [4:0] rd;
         logic [4:0] shamt;
         logic [5:0] funct;
      } r;
      struct packed {
         logic [5:0]  op;
         logic [4:0]  rs;
         logic [4:0]  rt;
         logic [15:0] imm16;
      } i;
      struct packed {
         logic [5:0]  op;
         logic [25:0] index26;
      } j;
   } instr_u;

endpackage

`default_nettype wire

// ==== design/instr_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_ctrl (
   input  mips_pkg::instr_u                 i_instr,
   output logic [mips_pkg::NB_EXT_SEL-1:0]  o_ext_mode,
   output logic [mips_pkg::NB_EXEC-1:0]     o_exec,
   output logic                             o_is_beq,
   output logic                             o_is_bne,
   output logic                             o_use_reg_target,
   output logic                             o_pc_src
);
   import mips_pkg::*;

   logic [3:0] alu_op;
   logic [1:0] a_sel;
   logic       b_sel;
   logic [1:0] dst_sel;
   logic       reg_jump;

   // JR and JALR take the target from rs
   assign reg_jump = (i_instr.r.funct == FN_JR) || (i_instr.r.funct == FN_JALR);

   assign o_exec = {alu_op, a_sel, b_sel, dst_sel};

   always_comb begin
      // nop word, used for unknown opcodes too
      o_ext_mode       = EXT_SGN;
      alu_op           = ALU_NONE;
      a_sel            = A_NONE;
      b_sel            = B_EXT;
      dst_sel          = DST_RD;
      o_is_beq         = 1'b0;
      o_is_bne         = 1'b0;
      o_use_reg_target = 1'b0;
      o_pc_src         = 1'b0;

      case (i_instr.r.op)
         OP_J: begin
            o_ext_mode = EXT_JMP;
            o_pc_src   = 1'b1;
         end
         OP_JAL: begin
            o_ext_mode = EXT_JMP;
            alu_op     = ALU_JAL;
            a_sel      = A_PC;     // return address from pc
            dst_sel    = DST_R31;
            o_pc_src   = 1'b1;
         end
         OP_BEQ: begin
            o_is_beq = 1'b1;      // compare done here, alu idle
         end
         OP_BNE: begin
            o_is_bne = 1'b1;
         end
         OP_ADDI: begin
            alu_op  = ALU_ADD;
            a_sel   = A_RS;
            dst_sel = DST_RT;
         end
         OP_SLTI: begin
            alu_op  = ALU_SLTI;
            a_sel   = A_RS;
            dst_sel = DST_RT;
         end
         OP_ANDI: begin
            o_ext_mode = EXT_ZRO;
            alu_op     = ALU_ANDI;
            a_sel      = A_RS;
            dst_sel    = DST_RT;
         end
         OP_ORI: begin
            o_ext_mode = EXT_ZRO;
            alu_op     = ALU_ORI;
            a_sel      = A_RS;
            dst_sel    = DST_RT;
         end
         OP_XORI: begin
            o_ext_mode = EXT_ZRO;
            alu_op     = ALU_XORI;
            a_sel      = A_RS;
            dst_sel    = DST_RT;
         end
         OP_LUI: begin
            o_ext_mode = EXT_ZRO;
            alu_op     = ALU_LUI;  // rs not read, a stays at A_NONE
            dst_sel    = DST_RT;
         end
         OP_LW, OP_SW: begin
            alu_op  = ALU_ADD;     // base plus offset
            a_sel   = A_RS;
            dst_sel = DST_RT;
         end
         OP_SPECIAL: begin
            o_ext_mode = EXT_SHAMT;
            alu_op     = ALU_FUNC;
            b_sel      = B_RT;
            case (i_instr.r.funct)
               FN_SLL, FN_SRL, FN_SRA: a_sel = A_EXT;  // shift by shamt
               FN_JALR:                a_sel = A_PC;
               default:                a_sel = A_RS;
            endcase
            o_use_reg_target = reg_jump;
            o_pc_src         = reg_jump;
         end
         default: begin
            o_ext_mode = EXT_SGN;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== design/imm_extend.sv ====
`timescale 1ns/1ps
`default_nettype none

module imm_extend (
   input  mips_pkg::instr_u                 i_instr,
   input  logic [mips_pkg::NB_EXT_SEL-1:0]  i_ext_mode,
   output logic [mips_pkg::NB_BITS-1:0]     o_ext_val
);
   import mips_pkg::*;

   always_comb begin
      case (i_ext_mode)
         EXT_JMP:   o_ext_val = {6'd0, i_instr.j.index26};
         EXT_SGN:   o_ext_val = {{16{i_instr.i.imm16[15]}}, i_instr.i.imm16};
         EXT_ZRO:   o_ext_val = {16'd0, i_instr.i.imm16};
         default:   o_ext_val = {27'd0, i_instr.r.shamt};  // EXT_SHAMT
      endcase
   end

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
   input  logic                          i_clk,
   input  logic                          i_rst,
   input  logic [mips_pkg::NB_REG-1:0]   i_rd_addr_1,
   input  logic [mips_pkg::NB_REG-1:0]   i_rd_addr_2,
   input  logic [mips_pkg::NB_REG-1:0]   i_wr_addr,
   input  logic [mips_pkg::NB_BITS-1:0]  i_wr_data,
   input  logic                          i_wr_en,
   output logic [mips_pkg::NB_BITS-1:0]  o_rd_data_1,
   output logic [mips_pkg::NB_BITS-1:0]  o_rd_data_2
);
   import mips_pkg::*;

   localparam int N_REGS = 2 ** NB_REG;

   logic [NB_BITS-1:0] regs [N_REGS];

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int k = 0; k < N_REGS; k++) begin
            regs[k] <= '0;
         end
      end else if (i_wr_en && (i_wr_addr != '0)) begin  // r0 never written
         regs[i_wr_addr] <= i_wr_data;
      end
   end

   // no write bypass, a read in the write cycle sees the old word
   assign o_rd_data_1 = (i_rd_addr_1 == '0) ? '0 : regs[i_rd_addr_1];
   assign o_rd_data_2 = (i_rd_addr_2 == '0) ? '0 : regs[i_rd_addr_2];

endmodule

`default_nettype wire

// ==== design/branch_target.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_target (
   input  logic [mips_pkg::NB_BITS-1:0]  i_pc,
   input  logic [mips_pkg::NB_BITS-1:0]  i_ext_val,
   input  logic [mips_pkg::NB_BITS-1:0]  i_rs_val,
   input  logic [mips_pkg::NB_BITS-1:0]  i_rt_val,
   input  logic                          i_is_beq,
   input  logic                          i_is_bne,
   input  logic                          i_use_reg_target,
   output logic [mips_pkg::NB_BITS-1:0]  o_brh_addr,
   output logic [mips_pkg::NB_BITS-1:0]  o_jmp_addr,
   output logic                          o_pc_beq
);
   import mips_pkg::*;

   logic regs_equal;

   assign regs_equal = (i_rs_val == i_rt_val);

   // word offset, wraps like two's complement
   assign o_brh_addr = i_pc + (i_ext_val << 2);

   // region jump keeps the top nibble of pc
   assign o_jmp_addr = i_use_reg_target ? i_rs_val :
                       {i_pc[NB_BITS-1:NB_JMP], i_ext_val[NB_JMP-3:0], 2'b00};

   assign o_pc_beq = (i_is_beq & regs_equal) | (i_is_bne & ~regs_equal);

endmodule

`default_nettype wire

// ==== design/id_ex_latch.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_ex_latch (
   input  logic                          i_clk,
   input  logic                          i_rst,
   input  logic [mips_pkg::NB_BITS-1:0]  i_pc,
   input  logic [mips_pkg::NB_BITS-1:0]  i_rs,
   input  logic [mips_pkg::NB_BITS-1:0]  i_rt,
   input  logic [mips_pkg::NB_BITS-1:0]  i_ext,
   input  logic [mips_pkg::NB_REG-1:0]   i_rt_num,
   input  logic [mips_pkg::NB_REG-1:0]   i_rd_num,
   input  logic [mips_pkg::NB_FUNC-1:0]  i_funct,
   input  logic [mips_pkg::NB_EXEC-1:0]  i_exec,
   output logic [mips_pkg::NB_BITS-1:0]  o_pc,
   output logic [mips_pkg::NB_BITS-1:0]  o_rs,
   output logic [mips_pkg::NB_BITS-1:0]  o_rt,
   output logic [mips_pkg::NB_BITS-1:0]  o_ext,
   output logic [mips_pkg::NB_REG-1:0]   o_rt_num,
   output logic [mips_pkg::NB_REG-1:0]   o_rd_num,
   output logic [mips_pkg::NB_FUNC-1:0]  o_funct,
   output logic [mips_pkg::NB_EXEC-1:0]  o_exec
);
   import mips_pkg::*;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_pc     <= '0;
         o_rs     <= '0;
         o_rt     <= '0;
         o_ext    <= '0;
         o_rt_num <= '0;
         o_rd_num <= '0;
         o_funct  <= '0;
         o_exec   <= '0;  // ALU_NONE, A_PC, B_RT, DST_RD
      end else begin
         // no stall, capture every cycle
         o_pc     <= i_pc;
         o_rs     <= i_rs;
         o_rt     <= i_rt;
         o_ext    <= i_ext;
         o_rt_num <= i_rt_num;
         o_rd_num <= i_rd_num;
         o_funct  <= i_funct;
         o_exec   <= i_exec;
      end
   end

endmodule

`default_nettype wire

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
   input  logic                          i_clk,
   input  logic                          i_rst,
   input  logic [mips_pkg::NB_BITS-1:0]  i_pc,
   input  logic [mips_pkg::NB_BITS-1:0]  i_instr,
   input  logic [mips_pkg::NB_BITS-1:0]  i_wb_data,
   input  logic [mips_pkg::NB_REG-1:0]   i_wb_dst,
   input  logic                          i_wb_we,
   output logic [mips_pkg::NB_BITS-1:0]  o_id_ex_pc,
   output logic [mips_pkg::NB_BITS-1:0]  o_id_ex_rs,
   output logic [mips_pkg::NB_BITS-1:0]  o_id_ex_rt,
   output logic [mips_pkg::NB_BITS-1:0]  o_id_ex_sgext,
   output logic [mips_pkg::NB_EXEC-1:0]  o_id_ex_exec,
   output logic [mips_pkg::NB_REG-1:0]   o_id_ex_rt_num,
   output logic [mips_pkg::NB_REG-1:0]   o_id_ex_rd_num,
   output logic [mips_pkg::NB_FUNC-1:0]  o_id_ex_func,
   output logic [mips_pkg::NB_BITS-1:0]  o_brh_addr,
   output logic [mips_pkg::NB_BITS-1:0]  o_jmp_addr,
   output logic                          o_pc_beq,
   output logic                          o_pc_src,
   output logic                          o_flush
);
   import mips_pkg::*;

   instr_u                instr;
   logic [NB_EXT_SEL-1:0] ext_mode;
   logic [NB_EXEC-1:0]    exec;
   logic                  is_beq;
   logic                  is_bne;
   logic                  use_reg_target;
   logic [NB_BITS-1:0]    rs_val;
   logic [NB_BITS-1:0]    rt_val;
   logic [NB_BITS-1:0]    ext_val;

   assign instr   = i_instr;
   assign o_flush = 1'b0;  // flush comes from hazard logic, not here

   instr_ctrl u_ctrl (
      .i_instr          (instr),
      .o_ext_mode       (ext_mode),
      .o_exec           (exec),
      .o_is_beq         (is_beq),
      .o_is_bne         (is_bne),
      .o_use_reg_target (use_reg_target),
      .o_pc_src         (o_pc_src)
   );

   imm_extend u_ext (
      .i_instr    (instr),
      .i_ext_mode (ext_mode),
      .o_ext_val  (ext_val)
   );

   reg_file u_rf (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_rd_addr_1 (instr.r.rs),
      .i_rd_addr_2 (instr.r.rt),
      .i_wr_addr   (i_wb_dst),   // write port driven by write-back
      .i_wr_data   (i_wb_data),
      .i_wr_en     (i_wb_we),
      .o_rd_data_1 (rs_val),
      .o_rd_data_2 (rt_val)
   );

   branch_target u_tgt (
      .i_pc             (i_pc),
      .i_ext_val        (ext_val),
      .i_rs_val         (rs_val),
      .i_rt_val         (rt_val),
      .i_is_beq         (is_beq),
      .i_is_bne         (is_bne),
      .i_use_reg_target (use_reg_target),
      .o_brh_addr       (o_brh_addr),
      .o_jmp_addr       (o_jmp_addr),
      .o_pc_beq         (o_pc_beq)
   );

   id_ex_latch u_id_ex (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_pc     (i_pc),
      .i_rs     (rs_val),
      .i_rt     (rt_val),
      .i_ext    (ext_val),
      .i_rt_num (instr.r.rt),
      .i_rd_num (instr.r.rd),
      .i_funct  (instr.r.funct),
      .i_exec   (exec),
      .o_pc     (o_id_ex_pc),
      .o_rs     (o_id_ex_rs),
      .o_rt     (o_id_ex_rt),
      .o_ext    (o_id_ex_sgext),
      .o_rt_num (o_id_ex_rt_num),
      .o_rd_num (o_id_ex_rd_num),
      .o_funct  (o_id_ex_func),
      .o_exec   (o_id_ex_exec)
   );

endmodule

`default_nettype wire

// ==== testbench/decode_tb_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_tb_assert (
   input logic                          i_clk,
   input logic                          i_rst,
   input logic                          i_flush,
   input logic                          i_pc_beq,
   input logic                          i_pc_src,
   input logic [mips_pkg::NB_EXEC-1:0]  i_id_ex_exec
);

   flush_low: assert property (@(posedge i_clk) !i_flush)
      else $error("o_flush went high");

   // branches and jumps never redirect together
   beq_not_with_jump: assert property (@(posedge i_clk) !(i_pc_beq && i_pc_src))
      else $error("o_pc_beq high while o_pc_src is high");

   exec_cleared: assert property (@(posedge i_clk) i_rst |=> (i_id_ex_exec == '0))
      else $error("o_id_ex_exec not cleared after reset");

endmodule

bind decode_stage decode_tb_assert u_assert (
   .i_clk        (i_clk),
   .i_rst        (i_rst),
   .i_flush      (o_flush),
   .i_pc_beq     (o_pc_beq),
   .i_pc_src     (o_pc_src),
   .i_id_ex_exec (o_id_ex_exec)
);

`default_nettype wire

// ==== testbench/decode_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_tb;
   import mips_pkg::*;

   localparam int          MAX_ROWS = 32;
   localparam logic [31:0] PC_BASE  = 32'ha000_0100;  // top nibble shows in j targets

   logic                i_clk = 1'b0;
   logic                i_rst;
   logic [NB_BITS-1:0]  i_pc;
   logic [NB_BITS-1:0]  i_instr;
   logic [NB_BITS-1:0]  i_wb_data;
   logic [NB_REG-1:0]   i_wb_dst;
   logic                i_wb_we;
   logic [NB_BITS-1:0]  o_id_ex_pc;
   logic [NB_BITS-1:0]  o_id_ex_rs;
   logic [NB_BITS-1:0]  o_id_ex_rt;
   logic [NB_BITS-1:0]  o_id_ex_sgext;
   logic [NB_EXEC-1:0]  o_id_ex_exec;
   logic [NB_REG-1:0]   o_id_ex_rt_num;
   logic [NB_REG-1:0]   o_id_ex_rd_num;
   logic [NB_FUNC-1:0]  o_id_ex_func;
   logic [NB_BITS-1:0]  o_brh_addr;
   logic [NB_BITS-1:0]  o_jmp_addr;
   logic                o_pc_beq;
   logic                o_pc_src;
   logic                o_flush;

   // stimulus table, flags are {beq, bne, reg target, pc_src}
   string              tbl_name  [MAX_ROWS];
   logic [31:0]        tbl_instr [MAX_ROWS];
   logic [NB_EXEC-1:0] tbl_exec  [MAX_ROWS];
   logic [1:0]         tbl_ext   [MAX_ROWS];
   logic [3:0]         tbl_flags [MAX_ROWS];
   int                 n_rows = 0;

   logic [31:0] model [32];  // expected register contents
   integer      seed = 34971;
   int          errors = 0;
   int          tests = 0;
   int          fails = 0;

   decode_stage dut_i (.*);

   always #5 i_clk = ~i_clk;

   function automatic logic [31:0] itype(input logic [5:0] op, input int rs, input int rt,
                                         input logic [15:0] imm);
      return {op, 5'(rs), 5'(rt), imm};
   endfunction

   function automatic logic [31:0] rtype(input int rs, input int rt, input int rd,
                                         input int sh, input logic [5:0] fn);
      return {OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
   endfunction

   // immediate alu ops all read rs, take the immediate and write rt
   function automatic logic [8:0] imm_word(input logic [3:0] alu);
      return {alu, A_RS, B_EXT, DST_RT};
   endfunction

   function automatic logic [8:0] func_word(input logic [1:0] a_sel);
      return {ALU_FUNC, a_sel, B_RT, DST_RD};
   endfunction

   function automatic logic [31:0] ext_rule(input logic [31:0] ins, input logic [1:0] mode);
      case (mode)
         EXT_JMP: return {6'd0, ins[25:0]};
         EXT_SGN: return {{16{ins[15]}}, ins[15:0]};
         EXT_ZRO: return {16'd0, ins[15:0]};
         default: return {27'd0, ins[10:6]};  // shamt
      endcase
   endfunction

   task automatic add_row(input string name, input logic [31:0] ins, input logic [8:0] exec,
                          input logic [1:0] ext, input logic [3:0] flags);
      tbl_name[n_rows]  = name;
      tbl_instr[n_rows] = ins;
      tbl_exec[n_rows]  = exec;
      tbl_ext[n_rows]   = ext;
      tbl_flags[n_rows] = flags;
      n_rows++;
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests++;
      if (errors != errs_before) begin
         fails++;
         $display("test %-8s FAILED", name);
      end else begin
         $display("test %-8s ok", name);
      end
   endtask

   task automatic build_table();
      logic [8:0] nop_w;
      nop_w = {ALU_NONE, A_NONE, B_EXT, DST_RD};
      add_row("addi", itype(OP_ADDI, 3, 4, 16'hfff0), imm_word(ALU_ADD), EXT_SGN, 4'h0);
      add_row("slti", itype(OP_SLTI, 5, 6, 16'h0012), imm_word(ALU_SLTI), EXT_SGN, 4'h0);
      add_row("andi", itype(OP_ANDI, 7, 8, 16'h8001), imm_word(ALU_ANDI), EXT_ZRO, 4'h0);
      add_row("ori", itype(OP_ORI, 9, 10, 16'hf00f), imm_word(ALU_ORI), EXT_ZRO, 4'h0);
      add_row("xori", itype(OP_XORI, 11, 12, 16'h5a5a), imm_word(ALU_XORI), EXT_ZRO, 4'h0);
      add_row("lui", itype(OP_LUI, 0, 13, 16'habcd),
              {ALU_LUI, A_NONE, B_EXT, DST_RT}, EXT_ZRO, 4'h0);
      add_row("lw", itype(OP_LW, 29, 14, 16'hfffc), imm_word(ALU_ADD), EXT_SGN, 4'h0);
      add_row("sw", itype(OP_SW, 29, 15, 16'h0008), imm_word(ALU_ADD), EXT_SGN, 4'h0);
      add_row("beq_eq", itype(OP_BEQ, 5, 5, 16'h0010), nop_w, EXT_SGN, 4'h8);
      add_row("beq_ne", itype(OP_BEQ, 5, 6, 16'h8000), nop_w, EXT_SGN, 4'h8);
      add_row("bne_eq", itype(OP_BNE, 7, 7, 16'h0020), nop_w, EXT_SGN, 4'h4);
      add_row("bne_ne", itype(OP_BNE, 7, 8, 16'hfff8), nop_w, EXT_SGN, 4'h4);
      add_row("j", {OP_J, 26'h1234567}, nop_w, EXT_JMP, 4'h1);
      add_row("jal", {OP_JAL, 26'h3000abc}, {ALU_JAL, A_PC, B_EXT, DST_R31}, EXT_JMP, 4'h1);
      add_row("sll", rtype(0, 11, 12, 17, FN_SLL), func_word(A_EXT), EXT_SHAMT, 4'h0);
      add_row("srl", rtype(0, 13, 14, 31, FN_SRL), func_word(A_EXT), EXT_SHAMT, 4'h0);
      add_row("sra", rtype(0, 15, 16, 1, FN_SRA), func_word(A_EXT), EXT_SHAMT, 4'h0);
      add_row("sllv", rtype(17, 18, 19, 0, FN_SLLV), func_word(A_RS), EXT_SHAMT, 4'h0);
      add_row("jr", rtype(20, 0, 0, 0, FN_JR), func_word(A_RS), EXT_SHAMT, 4'h3);
      add_row("jalr", rtype(21, 0, 31, 0, FN_JALR), func_word(A_PC), EXT_SHAMT, 4'h3);
      add_row("addu", rtype(22, 23, 24, 0, FN_ADDU), func_word(A_RS), EXT_SHAMT, 4'h0);
      add_row("slt", rtype(28, 30, 1, 0, FN_SLT), func_word(A_RS), EXT_SHAMT, 4'h0);
      add_row("bad_lb", itype(6'b100000, 2, 3, 16'h1234), nop_w, EXT_SGN, 4'h0);
      add_row("bad_sh", itype(6'b101001, 4, 5, 16'hffff), nop_w, EXT_SGN, 4'h0);
   endtask

   // called just after an edge, checks comb outputs then the latch after the next edge
   task automatic run_row(input int idx);
      logic [31:0] ins;
      logic [31:0] pc;
      logic [31:0] ext;
      logic [31:0] rs_v;
      logic [31:0] rt_v;
      logic [31:0] jmp;
      logic [3:0]  fl;
      logic        beq_exp;
      int          errs_before;
      errs_before = errors;
      ins  = tbl_instr[idx];
      pc   = PC_BASE + 32'(idx) * 32'd4;
      fl   = tbl_flags[idx];
      ext  = ext_rule(ins, tbl_ext[idx]);
      rs_v = model[ins[25:21]];
      rt_v = model[ins[20:16]];
      jmp  = fl[1] ? rs_v : {pc[31:28], ext[25:0], 2'b00};
      beq_exp = (fl[3] && (rs_v == rt_v)) || (fl[2] && (rs_v != rt_v));
      i_instr = ins;
      i_pc    = pc;
      #2;
      check_val("o_brh_addr", o_brh_addr, pc + (ext << 2));
      check_val("o_jmp_addr", o_jmp_addr, jmp);
      check_val("o_pc_beq", 32'(o_pc_beq), 32'(beq_exp));
      check_val("o_pc_src", 32'(o_pc_src), 32'(fl[0]));
      check_val("o_flush", 32'(o_flush), 32'd0);
      @(posedge i_clk);
      #1;
      check_val("o_id_ex_pc", o_id_ex_pc, pc);
      check_val("o_id_ex_rs", o_id_ex_rs, rs_v);
      check_val("o_id_ex_rt", o_id_ex_rt, rt_v);
      check_val("o_id_ex_sgext", o_id_ex_sgext, ext);
      check_val("o_id_ex_exec", 32'(o_id_ex_exec), 32'(tbl_exec[idx]));
      check_val("o_id_ex_rt_num", 32'(o_id_ex_rt_num), 32'(ins[20:16]));
      check_val("o_id_ex_rd_num", 32'(o_id_ex_rd_num), 32'(ins[15:11]));
      check_val("o_id_ex_func", 32'(o_id_ex_func), 32'(ins[5:0]));
      report_test(tbl_name[idx], errs_before);
   endtask

   initial begin
      int          errs_before;
      logic [31:0] old_val;
      i_rst     = 1'b1;
      i_pc      = PC_BASE;                     // busy inputs, latch must still clear
      i_instr   = rtype(1, 2, 3, 4, FN_SRA);
      i_wb_data = '0;
      i_wb_dst  = '0;
      i_wb_we   = 1'b0;
      build_table();
      repeat (16) @(posedge i_clk);
      #1;
      i_rst = 1'b0;

      errs_before = errors;
      check_val("o_id_ex_pc", o_id_ex_pc, 32'd0);
      check_val("o_id_ex_rs", o_id_ex_rs, 32'd0);
      check_val("o_id_ex_rt", o_id_ex_rt, 32'd0);
      check_val("o_id_ex_sgext", o_id_ex_sgext, 32'd0);
      check_val("o_id_ex_exec", 32'(o_id_ex_exec), 32'd0);
      check_val("o_id_ex_rt_num", 32'(o_id_ex_rt_num), 32'd0);
      check_val("o_id_ex_rd_num", 32'(o_id_ex_rd_num), 32'd0);
      check_val("o_id_ex_func", 32'(o_id_ex_func), 32'd0);
      report_test("reset", errs_before);

      // preload r1..r31 through the write-back port
      model[0] = '0;
      for (int r = 1; r < 32; r++) begin
         i_wb_we   = 1'b1;
         i_wb_dst  = 5'(r);
         i_wb_data = $random(seed);
         model[r]  = i_wb_data;
         @(posedge i_clk);
         #1;
      end

      // r0 must ignore the write
      errs_before = errors;
      i_wb_dst  = '0;
      i_wb_data = 32'hdead_beef;
      @(posedge i_clk);
      #1;
      i_wb_we = 1'b0;
      i_instr = rtype(0, 0, 3, 0, FN_ADDU);
      @(posedge i_clk);
      #1;
      check_val("o_id_ex_rs", o_id_ex_rs, 32'd0);
      check_val("o_id_ex_rt", o_id_ex_rt, 32'd0);
      report_test("r0_write", errs_before);

      // read and write of r7 in one cycle, no bypass
      errs_before = errors;
      old_val   = model[7];
      i_instr   = rtype(7, 7, 3, 0, FN_ADDU);
      i_wb_we   = 1'b1;
      i_wb_dst  = 5'd7;
      i_wb_data = ~old_val;
      @(posedge i_clk);
      #1;
      i_wb_we = 1'b0;
      model[7] = ~old_val;
      check_val("o_id_ex_rs", o_id_ex_rs, old_val);
      @(posedge i_clk);
      #1;
      check_val("o_id_ex_rt", o_id_ex_rt, model[7]);
      report_test("wr_rd", errs_before);

      for (int i = 0; i < n_rows; i++) begin
         run_row(i);
      end

      $display("%0d tests run, %0d failed, %0d errors", tests, fails, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   // watchdog, table is built at time 0
   initial begin
      #1;
      repeat (n_rows * 20 + 100) @(posedge i_clk);
      $display("timeout: the decode tests did not finish in time");
      $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/mips_pkg.sv
design/instr_ctrl.sv
design/imm_extend.sv
design/reg_file.sv
design/branch_target.sv
design/id_ex_latch.sv
design/decode_stage.sv
testbench/decode_tb_assert.sv
testbench/decode_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module decode_tb -o decode_tb_sim
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

out=$(./obj_dir/decode_tb_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "^No errors$"; then
   exit 0
fi
exit 1
